//--- cache_pkg.sv
/*
 * Cache geometry for the four-way data cache
 * Set and way counts, address field widths and bit positions
 */

package cache_pkg;

	// ========================================
	// Organisation
	// ========================================
	localparam int n_ways = 4;
	localparam int n_sets = 128;
	localparam int way_w = 2;

	// ========================================
	// Address fields of a 32-bit byte address
	// ========================================
	// Word offset inside a 16-byte line sits in bits 3 to 2
	localparam int word_w = 2;
	// Set index in bits 10 to 4
	localparam int idx_w = 7;
	localparam int idx_lsb = 4;
	// Tag in bits 31 to 11
	localparam int tag_w = 21;
	localparam int tag_lsb = 11;

endpackage

//--- mem_pkg.sv
/*
 * Memory-side constants and the cache controller state type
 */

package mem_pkg;

	// Memory port widths
	localparam int adr_w = 32;
	localparam int data_w = 32;

	// A line fill takes one single-word beat per word of the line
	localparam int line_words = 4;

	// Controller states
	typedef enum logic [2:0] {
		idle,
		lookup,
		fill,
		fill_done,
		write_mem,
		respond
	} ctrl_state_e;

endpackage

//--- dcache_tag.sv
/*
 * Tag store with per-way tag memory and a valid bit per line
 * Write of one way per cycle, combinational read of the whole set
 */
`timescale 1ns/1ps

module dcache_tag (
	input  logic clk,
	input  logic rst,
	input  logic wr,
	input  logic [cache_pkg::way_w-1:0] way,
	input  logic [cache_pkg::idx_w-1:0] idx,
	input  logic [cache_pkg::tag_w-1:0] wtag,
	output logic [cache_pkg::n_ways-1:0][cache_pkg::tag_w-1:0] rtags,
	output logic [cache_pkg::n_ways-1:0] rvalid
);

	// Tags for all ways live in one small memory, way number in the upper address bits
	logic [cache_pkg::tag_w-1:0] tags [0:cache_pkg::n_ways*cache_pkg::n_sets-1];
	// Valid bits are flops so that reset can clear every line at once
	logic [cache_pkg::n_ways-1:0] valid [0:cache_pkg::n_sets-1];

	always_ff @(posedge clk) begin
		if (wr)
			tags[{way, idx}] <= wtag;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < cache_pkg::n_sets; s++)
				valid[s] <= '0;
		end else if (wr) begin
			valid[idx][way] <= 1'b1;
		end
	end

	// Every way of the indexed set is presented in parallel to the comparators
	for (genvar g = 0; g < cache_pkg::n_ways; g++) begin : g_rd
		assign rtags[g] = tags[{cache_pkg::way_w'(g), idx}];
	end

	assign rvalid = valid[idx];

endmodule

//--- dcache_hit.sv
/*
 * Four-way tag comparator giving hit and the encoded hit way
 */
`timescale 1ns/1ps

module dcache_hit (
	input  logic [cache_pkg::n_ways-1:0][cache_pkg::tag_w-1:0] rtags,
	input  logic [cache_pkg::n_ways-1:0] rvalid,
	input  logic [cache_pkg::tag_w-1:0] tag,
	output logic hit,
	output logic [cache_pkg::way_w-1:0] hit_way
);

	logic [cache_pkg::n_ways-1:0] match;

	// All ways compare at once, only valid lines count
	always_comb begin
		for (int i = 0; i < cache_pkg::n_ways; i++)
			match[i] = rvalid[i] && (rtags[i] == tag);
	end

	assign hit = |match;

	// Encode the matching way, lowest number wins if the store were ever corrupt
	always_comb begin
		hit_way = '0;
		for (int i = cache_pkg::n_ways - 1; i >= 0; i--)
			if (match[i])
				hit_way = cache_pkg::way_w'(i);
	end

	// The controller only fills on a miss, so a tag can never be resident in two ways
	always_comb begin
		assert ($onehot0(match))
		else $error("FAILED: dcache_hit match=%h tag=%h", match, tag);
	end

endmodule

//--- dcache_plru.sv
/*
 * Tree pseudo-LRU state, three bits per set
 * Updated on each access and giving the replacement way
 */
`timescale 1ns/1ps

module dcache_plru (
	input  logic clk,
	input  logic rst,
	input  logic [cache_pkg::idx_w-1:0] idx,
	input  logic touch,
	input  logic [cache_pkg::way_w-1:0] touch_way,
	input  logic [cache_pkg::n_ways-1:0] rvalid,
	output logic [cache_pkg::way_w-1:0] victim
);

	// Bit 0 picks the pair, bit 1 picks within ways 0/1, bit 2 within ways 2/3
	logic [2:0] tree [0:cache_pkg::n_sets-1];
	logic [2:0] cur;
	logic [2:0] nxt;

	assign cur = tree[idx];

	// Point every bit on the path away from the way just used
	always_comb begin
		nxt = cur;
		nxt[0] = ~touch_way[1];
		if (touch_way[1])
			nxt[2] = ~touch_way[0];
		else
			nxt[1] = ~touch_way[0];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < cache_pkg::n_sets; s++)
				tree[s] <= '0;
		end else if (touch) begin
			tree[idx] <= nxt;
		end
	end

	// Follow the tree, but an empty way is always used first
	always_comb begin
		victim = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};
		for (int i = cache_pkg::n_ways - 1; i >= 0; i--)
			if (!rvalid[i])
				victim = cache_pkg::way_w'(i);
	end

endmodule

//--- dcache_data.sv
/*
 * Cache data store of 32-bit words
 * One shared address, synchronous read, single word write
 */
`timescale 1ns/1ps

module dcache_data (
	input  logic clk,
	input  logic [cache_pkg::idx_w-1:0] idx,
	input  logic [cache_pkg::way_w-1:0] way,
	input  logic [cache_pkg::word_w-1:0] word,
	input  logic wr,
	input  logic [mem_pkg::data_w-1:0] wdata,
	output logic [mem_pkg::data_w-1:0] rdata
);

	localparam int depth = 2 ** (cache_pkg::way_w + cache_pkg::idx_w + cache_pkg::word_w);

	logic [mem_pkg::data_w-1:0] words [0:depth-1];
	logic [cache_pkg::way_w+cache_pkg::idx_w+cache_pkg::word_w-1:0] addr;

	// Way in the top bits so each way is one contiguous block
	assign addr = {way, idx, word};

	// Read-before-write, a colliding read sees the old word
	always_ff @(posedge clk) begin
		if (wr)
			words[addr] <= wdata;
		rdata <= words[addr];
	end

endmodule

//--- dcache_ctrl.sv
/*
 * Cache controller FSM for lookup, line fill, write-through and response
 * Latches one request at a time and drives the memory port
 */
`timescale 1ns/1ps

module dcache_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic req,
	input  logic we,
	input  logic [mem_pkg::adr_w-1:0] adr,
	input  logic [mem_pkg::data_w-1:0] wdata,
	output logic ready,
	output logic done,
	output logic [mem_pkg::data_w-1:0] rdata,
	output logic [cache_pkg::idx_w-1:0] idx,
	output logic [cache_pkg::tag_w-1:0] tag,
	input  logic hit,
	input  logic [cache_pkg::way_w-1:0] hit_way,
	input  logic [cache_pkg::way_w-1:0] victim,
	output logic tag_wr,
	output logic [cache_pkg::way_w-1:0] tag_way,
	output logic data_wr,
	output logic [cache_pkg::way_w-1:0] data_way,
	output logic [cache_pkg::word_w-1:0] data_word,
	output logic [mem_pkg::data_w-1:0] data_wdata,
	input  logic [mem_pkg::data_w-1:0] data_rdata,
	output logic touch,
	output logic [cache_pkg::way_w-1:0] touch_way,
	output logic mem_req,
	output logic mem_we,
	output logic [mem_pkg::adr_w-1:0] mem_adr,
	output logic [mem_pkg::data_w-1:0] mem_wdata,
	input  logic mem_ack,
	input  logic [mem_pkg::data_w-1:0] mem_rdata
);

	mem_pkg::ctrl_state_e state;

	// Request captured when it is accepted
	logic [mem_pkg::adr_w-1:0] cur_adr;
	logic cur_we;
	logic [mem_pkg::data_w-1:0] cur_wdata;
	logic [cache_pkg::word_w-1:0] cur_word;
	// Way chosen for the line being filled and the beat in progress
	logic [cache_pkg::way_w-1:0] fill_way;
	logic [cache_pkg::word_w-1:0] beat;
	logic last_beat;

	assign tag = cur_adr[cache_pkg::tag_lsb +: cache_pkg::tag_w];
	assign idx = cur_adr[cache_pkg::idx_lsb +: cache_pkg::idx_w];
	assign cur_word = cur_adr[cache_pkg::idx_lsb - cache_pkg::word_w +: cache_pkg::word_w];
	assign last_beat = (beat == cache_pkg::word_w'(mem_pkg::line_words - 1));

	// ========================================
	// State sequencing
	// ========================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mem_pkg::idle;
			beat <= '0;
		end else begin
			case (state)
			mem_pkg::idle:
				if (req)
					state <= mem_pkg::lookup;
			mem_pkg::lookup:
				// Writes always go through to memory whether they hit or not
				if (cur_we) begin
					state <= mem_pkg::write_mem;
				end else if (hit) begin
					state <= mem_pkg::respond;
				end else begin
					state <= mem_pkg::fill;
					beat <= '0;
				end
			mem_pkg::fill:
				if (mem_ack) begin
					beat <= beat + 1'b1;
					if (last_beat)
						state <= mem_pkg::fill_done;
				end
			mem_pkg::fill_done:
				state <= mem_pkg::respond;
			mem_pkg::write_mem:
				if (mem_ack)
					state <= mem_pkg::respond;
			mem_pkg::respond:
				state <= mem_pkg::idle;
			default:
				state <= mem_pkg::idle;
			endcase
		end
	end

	// Payload capture
	always_ff @(posedge clk) begin
		if (state == mem_pkg::idle && req) begin
			cur_adr <= adr;
			cur_we <= we;
			cur_wdata <= wdata;
		end
		// Victim is frozen at lookup since the tree changes when the fill completes
		if (state == mem_pkg::lookup)
			fill_way <= victim;
	end

	// ========================================
	// Outputs
	// ========================================
	assign ready = (state == mem_pkg::idle);
	assign done = (state == mem_pkg::respond);
	assign rdata = data_rdata;

	// The tag goes in with the last beat so the line never looks valid half filled
	assign tag_wr = (state == mem_pkg::fill) && mem_ack && last_beat;
	assign tag_way = fill_way;

	// Data store takes fill beats and also write hits during lookup
	assign data_wr = (state == mem_pkg::fill && mem_ack)
		|| (state == mem_pkg::lookup && cur_we && hit);
	assign data_way = (state == mem_pkg::lookup) ? hit_way : fill_way;
	assign data_word = (state == mem_pkg::fill) ? beat : cur_word;
	assign data_wdata = (state == mem_pkg::fill) ? mem_rdata : cur_wdata;

	assign touch = (state == mem_pkg::lookup && hit) || tag_wr;
	assign touch_way = (state == mem_pkg::lookup) ? hit_way : fill_way;

	// Fill reads walk the line from word 0 while writes use the request address
	assign mem_req = (state == mem_pkg::fill) || (state == mem_pkg::write_mem);
	assign mem_we = (state == mem_pkg::write_mem);
	assign mem_adr = (state == mem_pkg::write_mem) ? cur_adr
		: {tag, idx, beat, {(cache_pkg::idx_lsb - cache_pkg::word_w){1'b0}}};
	assign mem_wdata = cur_wdata;

	// Memory request is held with a steady address until memory acknowledges
	a_mem_hold: assert property (@(posedge clk) disable iff (rst)
		mem_req && !mem_ack |=> mem_req && $stable(mem_adr) && $stable(mem_we))
	else $error("FAILED: mem_req dropped or mem_adr=%h changed before mem_ack", mem_adr);

	// A read is answered only once its line is resident in the tag store
	a_read_resident: assert property (@(posedge clk) disable iff (rst)
		done && !cur_we |-> hit)
	else $error("Read response for address %h given while its line is not cached", cur_adr);

endmodule

//--- dcache_top.sv
/*
 * Data cache top level
 * Connects controller, tag store, comparator, pseudo-LRU and data store
 */
`timescale 1ns/1ps

module dcache_top (
	input  logic clk,
	input  logic rst,
	input  logic req,
	input  logic we,
	input  logic [mem_pkg::adr_w-1:0] adr,
	input  logic [mem_pkg::data_w-1:0] wdata,
	output logic ready,
	output logic done,
	output logic [mem_pkg::data_w-1:0] rdata,
	output logic mem_req,
	output logic mem_we,
	output logic [mem_pkg::adr_w-1:0] mem_adr,
	output logic [mem_pkg::data_w-1:0] mem_wdata,
	input  logic mem_ack,
	input  logic [mem_pkg::data_w-1:0] mem_rdata
);

	// Lookup path
	logic [cache_pkg::idx_w-1:0] idx;
	logic [cache_pkg::tag_w-1:0] tag;
	logic [cache_pkg::n_ways-1:0][cache_pkg::tag_w-1:0] rtags;
	logic [cache_pkg::n_ways-1:0] rvalid;
	logic hit;
	logic [cache_pkg::way_w-1:0] hit_way;
	logic [cache_pkg::way_w-1:0] victim;
	// Update path
	logic tag_wr;
	logic [cache_pkg::way_w-1:0] tag_way;
	logic data_wr;
	logic [cache_pkg::way_w-1:0] data_way;
	logic [cache_pkg::word_w-1:0] data_word;
	logic [mem_pkg::data_w-1:0] data_wdata;
	logic [mem_pkg::data_w-1:0] data_rdata;
	logic touch;
	logic [cache_pkg::way_w-1:0] touch_way;

	dcache_ctrl u_ctrl (.*);

	dcache_tag u_tag (
		.clk(clk), .rst(rst), .wr(tag_wr), .way(tag_way), .idx(idx), .wtag(tag),
		.rtags(rtags), .rvalid(rvalid)
	);

	dcache_hit u_hit (.rtags(rtags), .rvalid(rvalid), .tag(tag), .hit(hit), .hit_way(hit_way));

	dcache_plru u_plru (
		.clk(clk), .rst(rst), .idx(idx), .touch(touch), .touch_way(touch_way),
		.rvalid(rvalid), .victim(victim)
	);

	dcache_data u_data (
		.clk(clk), .idx(idx), .way(data_way), .word(data_word), .wr(data_wr),
		.wdata(data_wdata), .rdata(data_rdata)
	);

endmodule

//--- tb_clock.sv
/*
 * Testbench clock source with a 100 ns period
 */
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	// Half of the 100 ns period, in timescale units
	localparam int half_period = 50;

	initial clk = 1'b0;

	always #(half_period) clk = ~clk;

endmodule

//--- tb_mem.sv
/*
 * Behavioral word memory for the cache's memory port
 * Random acknowledge delay of 0 to 3 cycles and a shadow of all writes
 */
`timescale 1ns/1ps

module tb_mem (
	input  logic clk,
	input  logic rst,
	input  logic mem_req,
	input  logic mem_we,
	input  logic [mem_pkg::adr_w-1:0] mem_adr,
	input  logic [mem_pkg::data_w-1:0] mem_wdata,
	output logic mem_ack,
	output logic [mem_pkg::data_w-1:0] mem_rdata
);

	// Only written words are stored and all others are computed from their address
	logic [mem_pkg::data_w-1:0] shadow [logic [mem_pkg::adr_w-1:0]];
	logic pending;
	int unsigned wait_left;

	// Untouched memory holds its own address exclusive-ored with a fixed pattern
	function automatic logic [mem_pkg::data_w-1:0] read_word(input logic [mem_pkg::adr_w-1:0] a);
		if (shadow.exists(a))
			return shadow[a];
		return a ^ 32'h5a5a0000;
	endfunction

	initial begin
		mem_ack = 1'b0;
		mem_rdata = '0;
		pending = 1'b0;
		wait_left = 0;
		// One seed for the whole run keeps the delays repeatable
		void'($urandom(32'h48da));
	end

	// Everything toward the DUT changes on the falling edge
	always @(negedge clk) begin
		// An acknowledge seen at the last rising edge closes that request
		if (mem_ack)
			pending = 1'b0;
		mem_ack = 1'b0;
		if (rst) begin
			pending = 1'b0;
		end else if (mem_req) begin
			if (!pending) begin
				pending = 1'b1;
				wait_left = $urandom % 4;
			end
			if (wait_left == 0) begin
				mem_ack = 1'b1;
				if (mem_we)
					shadow[mem_adr] = mem_wdata;
				else
					mem_rdata = read_word(mem_adr);
			end else begin
				wait_left--;
			end
		end
	end

endmodule

//--- tb_dcache.sv
/*
 * Testbench top for the four-way data cache
 * Replays the stimulus file, watches the memory port and checks every response
 */
`timescale 1ns/1ps

module tb_dcache;

	localparam int max_ops = 32;
	localparam logic [31:0] op_read = 32'h0;
	localparam logic [31:0] op_write = 32'h1;
	localparam logic [31:0] op_end = 32'hf;

	logic clk;
	logic rst;
	logic req;
	logic we;
	logic [31:0] adr;
	logic [31:0] wdata;
	logic ready;
	logic done;
	logic [31:0] rdata;
	logic mem_req;
	logic mem_we;
	logic [31:0] mem_adr;
	logic [31:0] mem_wdata;
	logic mem_ack;
	logic [31:0] mem_rdata;

	// Five words per operation: op, address, write data, expected read data, fill flag
	logic [31:0] stim [0:5*max_ops-1];
	int n_ops;
	int op_i;

	// Running totals kept by the port monitor
	int rd_total;
	int wr_total;
	int done_total;
	// Snapshot of the totals and the request currently in flight
	int rd_start;
	int wr_start;
	int done_start;
	logic [31:0] op_adr;
	logic [31:0] op_wdata;
	logic [31:0] exp_fill_adr;

	int data_errs;
	int mem_errs;
	int proto_errs;

	tb_clock u_clock (.clk(clk));

	tb_mem u_mem (
		.clk(clk), .rst(rst), .mem_req(mem_req), .mem_we(mem_we), .mem_adr(mem_adr),
		.mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
	);

	dcache_top DUT (.*);

	// ========================================
	// Memory port and done monitor
	// ========================================
	// Sampled on the rising edge, where mem_ack has been steady for half a cycle
	always @(posedge clk) begin
		if (!rst && done)
			done_total++;
		if (!rst && mem_req && mem_ack) begin
			if (mem_we) begin
				wr_total++;
				if (mem_adr != op_adr) begin
					$display("FAILED: mem_adr got %h expected %h", mem_adr, op_adr);
					mem_errs++;
				end
				if (mem_wdata != op_wdata) begin
					$display("FAILED: mem_wdata got %h expected %h", mem_wdata, op_wdata);
					mem_errs++;
				end
			end else begin
				// Fill beats walk the line from word 0 upward
				exp_fill_adr = {op_adr[31:4], 2'(rd_total - rd_start), 2'b00};
				if (mem_adr != exp_fill_adr) begin
					$display("FAILED: mem_adr got %h expected %h", mem_adr, exp_fill_adr);
					mem_errs++;
				end
				rd_total++;
			end
		end
	end

	// ========================================
	// One processor access
	// ========================================
	task automatic run_op(input int n);
		logic [31:0] op;
		logic [31:0] a;
		logic [31:0] wd;
		logic [31:0] exp_rd;
		logic [31:0] exp_fill;
		int latency;
		int exp_beats;
		op = stim[5*n];
		a = stim[5*n+1];
		wd = stim[5*n+2];
		exp_rd = stim[5*n+3];
		exp_fill = stim[5*n+4];
		exp_beats = (exp_fill != 0) ? mem_pkg::line_words : 0;
		while (!ready)
			@(negedge clk);
		op_adr = a;
		op_wdata = wd;
		rd_start = rd_total;
		wr_start = wr_total;
		done_start = done_total;
		req = 1'b1;
		we = (op == op_write);
		adr = a;
		wdata = wd;
		@(negedge clk);
		req = 1'b0;
		we = 1'b0;
		adr = '0;
		wdata = '0;
		if (ready) begin
			$display("Error: op %0d to %h was not accepted by the cache", n + 1, a);
			proto_errs++;
		end
		// Counted in rising edges after the one that took the request
		latency = 1;
		while (!done) begin
			@(negedge clk);
			latency++;
		end
		if (op == op_read) begin
			if (rdata != exp_rd) begin
				$display("FAILED: rdata got %h expected %h (op %0d)", rdata, exp_rd, n + 1);
				data_errs++;
			end
			if (exp_fill == 0 && latency != 2) begin
				$display("FAILED: done latency got %h expected %h (op %0d)", latency, 2, n + 1);
				proto_errs++;
			end
		end
		@(negedge clk);
		if (!ready) begin
			$display("Error: ready stayed low after done on op %0d", n + 1);
			proto_errs++;
		end
		if (done_total - done_start != 1) begin
			$display("Error: op %0d saw %0d done pulses", n + 1, done_total - done_start);
			proto_errs++;
		end
		if (rd_total - rd_start != exp_beats) begin
			$display("FAILED: fill beats got %h expected %h (op %0d)",
				rd_total - rd_start, exp_beats, n + 1);
			proto_errs++;
		end
		if (wr_total - wr_start != ((op == op_write) ? 1 : 0)) begin
			$display("FAILED: write beats got %h expected %h (op %0d)",
				wr_total - wr_start, (op == op_write) ? 1 : 0, n + 1);
			proto_errs++;
		end
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial begin
		rst = 1'b1;
		req = 1'b0;
		we = 1'b0;
		adr = '0;
		wdata = '0;
		n_ops = 0;
		rd_total = 0;
		wr_total = 0;
		done_total = 0;
		rd_start = 0;
		op_adr = '0;
		op_wdata = '0;
		data_errs = 0;
		mem_errs = 0;
		proto_errs = 0;
		$readmemh("dcache_stim.txt", stim);
		while (n_ops < max_ops && stim[5*n_ops] !== op_end)
			n_ops++;
		if (n_ops == 0) begin
			$display("Error: the stimulus file holds no operations");
			proto_errs++;
		end
		repeat (16) @(negedge clk);
		rst = 1'b0;
		// Idle state straight out of reset
		if (!ready || done || mem_req) begin
			$display("FAILED: after reset ready=%h done=%h mem_req=%h", ready, done, mem_req);
			proto_errs++;
		end
		for (op_i = 0; op_i < n_ops; op_i++)
			run_op(op_i);
		$display("Errors: read data %0d, memory port %0d, protocol %0d",
			data_errs, mem_errs, proto_errs);
		if (data_errs + mem_errs + proto_errs == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// Each operation gets 40 cycles on top of the reset time
	initial begin
		wait (n_ops > 0);
		repeat (16 + n_ops * 40) @(posedge clk);
		$display("Error: timeout, the run did not finish in %0d cycles", 16 + n_ops * 40);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- dcache_stim.txt
// op address wdata exp_rdata fill, all in hex
// op 0 is a read, 1 a write, f ends the list; fill 1 means the read refills a line
0 00000100 00000000 5a5a0100 1
0 0000010c 00000000 5a5a010c 0
0 00000104 00000000 5a5a0104 0
1 00000108 12345678 00000000 0
0 00000108 00000000 12345678 0
1 00004200 cafef00d 00000000 0
0 00004200 00000000 cafef00d 1
0 00004204 00000000 5a5a4204 0
0 fffff7f0 00000000 a5a5f7f0 1
0 00000030 00000000 5a5a0030 1
0 00000830 00000000 5a5a0830 1
0 00001030 00000000 5a5a1030 1
0 00001830 00000000 5a5a1830 1
0 00000034 00000000 5a5a0034 0
0 00002030 00000000 5a5a2030 1
0 00000838 00000000 5a5a0838 0
0 00001030 00000000 5a5a1030 1
0 0000003c 00000000 5a5a003c 0
0 00002034 00000000 5a5a2034 0
0 00001830 00000000 5a5a1830 1
0 00000830 00000000 5a5a0830 1
0 00002030 00000000 5a5a2030 0
1 00001838 0badc0de 00000000 0
0 00001838 00000000 0badc0de 0
f 00000000 00000000 00000000 0

//--- filelist.f
cache_pkg.sv
mem_pkg.sv
dcache_tag.sv
dcache_hit.sv
dcache_plru.sv
dcache_data.sv
dcache_ctrl.sv
dcache_top.sv
tb_clock.sv
tb_mem.sv
tb_dcache.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_dcache -f filelist.f -o sim_dcache
./obj_dir/sim_dcache 2>&1 | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
